//--- design/lsu_pkg.sv
// ######################################################################
// Shared LSU types. The data memory window starts at byte address 0
// and anything at or above DMEM_BYTES is reported as an access fault
// ######################################################################
`default_nettype none

package lsu_pkg;

    // Width of a data word, which is also the width of a byte address
    localparam int DATA_WIDTH = 32;

    // Size of the tightly coupled data memory that stands in for the D$
    localparam int DMEM_BYTES = 1024;

    // The memory is organized as whole words, four byte lanes each
    localparam int DMEM_WORDS = DMEM_BYTES / 4;

    // One data word as it moves between the stages
    typedef logic [DATA_WIDTH-1:0] lsu_data_t;

    // A full byte address, before any window check
    typedef logic [DATA_WIDTH-1:0] lsu_addr_t;

    // Destination tag, carried along unchanged so the core can match results
    typedef logic [5:0] lsu_tag_t;

    // Memory operation selector
    // The first five codes are loads and the top three are stores
    typedef enum logic [2:0] {
        LSU_FUNC_LB  = 3'b000,
        LSU_FUNC_LH  = 3'b001,
        LSU_FUNC_LW  = 3'b010,
        LSU_FUNC_LBU = 3'b011,
        LSU_FUNC_LHU = 3'b100,
        LSU_FUNC_SB  = 3'b101,
        LSU_FUNC_SH  = 3'b110,
        LSU_FUNC_SW  = 3'b111
    } lsu_func_t;

endpackage

`default_nettype wire

//--- design/lsu_ag.sv
// ######################################################################
// Address generation. One operation per clock, no stall input, so the
// registered outputs always hold the operation accepted one cycle back
// ######################################################################
`timescale 1ns/1ps
`default_nettype none

module lsu_ag
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      i_arst_n,

    // Operation from issue
    input  logic      i_valid,
    input  lsu_func_t i_func,
    input  lsu_addr_t i_base,
    input  lsu_addr_t i_offset,
    input  lsu_tag_t  i_tag,
    input  lsu_data_t i_store_data,

    // Registered operation towards the execute stage
    output logic      o_valid,
    output lsu_func_t o_func,
    output lsu_addr_t o_addr,
    output lsu_tag_t  o_tag,
    output lsu_data_t o_store_data,
    output logic      o_misaligned
);

    // Effective address of the access
    lsu_addr_t addr_sum;

    // Alignment verdict for the current operation
    logic      misaligned;

    // Base plus offset, wrapping at 32 bits like the integer adder would
    assign addr_sum = i_base + i_offset;

    // Halfwords need an even address and words need a multiple of 4
    // Byte accesses can never be misaligned
    always_comb begin
        case (i_func)
            LSU_FUNC_LH:  misaligned = addr_sum[0];
            LSU_FUNC_LHU: misaligned = addr_sum[0];
            LSU_FUNC_SH:  misaligned = addr_sum[0];
            LSU_FUNC_LW:  misaligned = |addr_sum[1:0];
            LSU_FUNC_SW:  misaligned = |addr_sum[1:0];
            default:      misaligned = 1'b0;
        endcase
    end

    // Only the valid bit needs a known value out of reset
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    // Payload follows the input every cycle
    // Downstream logic qualifies all of it with o_valid
    always_ff @(posedge clk) begin
        o_func       <= i_func;
        o_addr       <= addr_sum;
        o_tag        <= i_tag;
        o_store_data <= i_store_data;
        o_misaligned <= misaligned;
    end

endmodule

`default_nettype wire

//--- design/lsu_dmem.sv
// ######################################################################
// Data memory for the D$ slot. Contents are undefined until written.
// Reads are combinational, writes land on the clock edge
// ######################################################################
`timescale 1ns/1ps
`default_nettype none

module lsu_dmem
    import lsu_pkg::*;
(
    input  logic      clk,

    // Access request from the execute stage
    input  logic      i_re,
    input  logic      i_we,
    input  lsu_addr_t i_addr,
    input  lsu_func_t i_func,
    input  lsu_data_t i_wdata,

    // Window hit and read data, both combinational
    output logic      o_hit,
    output lsu_data_t o_data
);

    // Word storage, one entry per aligned 32-bit word
    lsu_data_t                     mem [DMEM_WORDS];

    // Word select and byte position inside the word
    logic [$clog2(DMEM_WORDS)-1:0] word_idx;
    logic [1:0]                    byte_off;
    logic [4:0]                    bit_off;

    // Raw word read out of the array
    lsu_data_t                     rd_word;

    // Lane enables and lane-aligned data for a store
    logic [3:0]                    byte_en;
    lsu_data_t                     wr_word;

    // The window starts at 0, so any address below its size is a hit
    assign o_hit    = (i_addr < lsu_addr_t'(DMEM_BYTES));

    // Upper bits beyond the window are ignored for indexing
    // A miss never reaches the array because o_hit gates both paths
    assign word_idx = i_addr[$clog2(DMEM_BYTES)-1:2];
    assign byte_off = i_addr[1:0];
    assign bit_off  = {byte_off, 3'b000};

    assign rd_word  = mem[word_idx];

    // The addressed byte or halfword ends up in the low bits
    // The execute stage then extends it as the function asks
    assign o_data   = (i_re && o_hit) ? (rd_word >> bit_off) : '0;

    // Store data is moved up to the lane it belongs to
    assign wr_word  = i_wdata << bit_off;

    // Lanes touched by each store size
    // Halfword and word stores arrive aligned, so nothing spills past lane 3
    always_comb begin
        case (i_func)
            LSU_FUNC_SB: byte_en = 4'b0001 << byte_off;
            LSU_FUNC_SH: byte_en = 4'b0011 << byte_off;
            LSU_FUNC_SW: byte_en = 4'b1111;
            default:     byte_en = 4'b0000;
        endcase
    end

    // Byte-lane write at the edge that closes the execute cycle
    // so a load one cycle behind already sees the new data
    always_ff @(posedge clk) begin
        if (i_we && o_hit) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[word_idx][8*b +: 8] <= wr_word[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/lsu_ex.sv
// ######################################################################
// Execute stage, purely combinational. Stores complete here, and only
// loads return data; misses and misalignment are reported as faults
// ######################################################################
`timescale 1ns/1ps
`default_nettype none

module lsu_ex
    import lsu_pkg::*;
(
    // Operation from address generation
    input  logic      i_valid,
    input  lsu_func_t i_func,
    input  lsu_addr_t i_addr,
    input  lsu_tag_t  i_tag,
    input  lsu_data_t i_store_data,
    input  logic      i_misaligned,

    // Data memory response
    input  logic      i_dc_hit,
    input  lsu_data_t i_dc_data,

    // Data memory request
    output lsu_addr_t o_dc_addr,
    output logic      o_dc_re,
    output logic      o_dc_we,
    output lsu_data_t o_dc_wdata,
    output lsu_func_t o_dc_func,

    // Result towards writeback
    output lsu_data_t o_data,
    output lsu_addr_t o_addr,
    output lsu_tag_t  o_tag,
    output logic      o_valid,
    output logic      o_fault
);

    // Store functions sit at the top of the encoding
    logic is_store;

    assign is_store   = (i_func == LSU_FUNC_SB) || (i_func == LSU_FUNC_SH) ||
                        (i_func == LSU_FUNC_SW);

    // A misaligned access never reaches the memory
    assign o_dc_addr  = i_addr;
    assign o_dc_re    = i_valid && !is_store && !i_misaligned;
    assign o_dc_we    = i_valid && is_store && !i_misaligned;
    assign o_dc_wdata = i_store_data;
    assign o_dc_func  = i_func;

    assign o_addr     = i_addr;
    assign o_tag      = i_tag;

    // Every accepted operation reports back, stores included
    assign o_valid    = i_valid;

    // Outside the window counts as a fault just like bad alignment
    assign o_fault    = i_valid && (i_misaligned || !i_dc_hit);

    // LB and LH sign extend the low byte or halfword to a full word
    // LBU and LHU zero extend instead
    always_comb begin
        case (i_func)
            LSU_FUNC_LB:  o_data = {{(DATA_WIDTH-8){i_dc_data[7]}}, i_dc_data[7:0]};
            LSU_FUNC_LH:  o_data = {{(DATA_WIDTH-16){i_dc_data[15]}}, i_dc_data[15:0]};
            LSU_FUNC_LBU: o_data = {{(DATA_WIDTH-8){1'b0}}, i_dc_data[7:0]};
            LSU_FUNC_LHU: o_data = {{(DATA_WIDTH-16){1'b0}}, i_dc_data[15:0]};
            default:      o_data = i_dc_data;
        endcase
    end

endmodule

`default_nettype wire

//--- design/lsu_wb.sv
// ######################################################################
// Writeback register. Each result is held for exactly one cycle with
// o_valid, and o_data means nothing for stores or faults
// ######################################################################
`timescale 1ns/1ps
`default_nettype none

module lsu_wb
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      i_arst_n,

    // Result from the execute stage
    input  logic      i_valid,
    input  lsu_data_t i_data,
    input  lsu_addr_t i_addr,
    input  lsu_tag_t  i_tag,
    input  logic      i_fault,

    // Registered result back to the core
    output logic      o_valid,
    output lsu_data_t o_data,
    output lsu_addr_t o_addr,
    output lsu_tag_t  o_tag,
    output logic      o_fault
);

    // Valid and fault are control, so both come out of reset low
    // The fault flag arrives already qualified by valid
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid <= 1'b0;
            o_fault <= 1'b0;
        end else begin
            o_valid <= i_valid;
            o_fault <= i_fault;
        end
    end

    // Result payload, captured every cycle
    always_ff @(posedge clk) begin
        o_data <= i_data;
        o_addr <= i_addr;
        o_tag  <= i_tag;
    end

endmodule

`default_nettype wire

//--- design/lsu_top.sv
// ######################################################################
// Load/store path. Results come back two cycles after issue, in order,
// with no back-pressure, so the caller must accept every o_valid
// ######################################################################
`timescale 1ns/1ps
`default_nettype none

module lsu_top
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      i_arst_n,

    // Issue side
    input  logic      i_valid,
    input  lsu_func_t i_func,
    input  lsu_addr_t i_base,
    input  lsu_addr_t i_offset,
    input  lsu_tag_t  i_tag,
    input  lsu_data_t i_store_data,

    // Writeback side
    output logic      o_valid,
    output lsu_data_t o_data,
    output lsu_addr_t o_addr,
    output lsu_tag_t  o_tag,
    output logic      o_fault
);

    // Address generation to execute
    logic      ag_valid;
    lsu_func_t ag_func;
    lsu_addr_t ag_addr;
    lsu_tag_t  ag_tag;
    lsu_data_t ag_store_data;
    logic      ag_misaligned;

    // Execute to and from the data memory
    lsu_addr_t dc_addr;
    logic      dc_re;
    logic      dc_we;
    lsu_data_t dc_wdata;
    lsu_func_t dc_func;
    logic      dc_hit;
    lsu_data_t dc_data;

    // Execute to writeback
    logic      ex_valid;
    lsu_data_t ex_data;
    lsu_addr_t ex_addr;
    lsu_tag_t  ex_tag;
    logic      ex_fault;

    lsu_ag lsu_ag_i (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_valid      (i_valid),
        .i_func       (i_func),
        .i_base       (i_base),
        .i_offset     (i_offset),
        .i_tag        (i_tag),
        .i_store_data (i_store_data),
        .o_valid      (ag_valid),
        .o_func       (ag_func),
        .o_addr       (ag_addr),
        .o_tag        (ag_tag),
        .o_store_data (ag_store_data),
        .o_misaligned (ag_misaligned)
    );

    lsu_ex lsu_ex_i (
        .i_valid      (ag_valid),
        .i_func       (ag_func),
        .i_addr       (ag_addr),
        .i_tag        (ag_tag),
        .i_store_data (ag_store_data),
        .i_misaligned (ag_misaligned),
        .i_dc_hit     (dc_hit),
        .i_dc_data    (dc_data),
        .o_dc_addr    (dc_addr),
        .o_dc_re      (dc_re),
        .o_dc_we      (dc_we),
        .o_dc_wdata   (dc_wdata),
        .o_dc_func    (dc_func),
        .o_data       (ex_data),
        .o_addr       (ex_addr),
        .o_tag        (ex_tag),
        .o_valid      (ex_valid),
        .o_fault      (ex_fault)
    );

    lsu_dmem lsu_dmem_i (
        .clk     (clk),
        .i_re    (dc_re),
        .i_we    (dc_we),
        .i_addr  (dc_addr),
        .i_func  (dc_func),
        .i_wdata (dc_wdata),
        .o_hit   (dc_hit),
        .o_data  (dc_data)
    );

    lsu_wb lsu_wb_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_valid  (ex_valid),
        .i_data   (ex_data),
        .i_addr   (ex_addr),
        .i_tag    (ex_tag),
        .i_fault  (ex_fault),
        .o_valid  (o_valid),
        .o_data   (o_data),
        .o_addr   (o_addr),
        .o_tag    (o_tag),
        .o_fault  (o_fault)
    );

endmodule

`default_nettype wire

//--- verif/lsu_asserts.sv
// ######################################################################
// Protocol checks bound into lsu_top. They look at internal wires, so
// they follow the stage signal names used inside the top level
// ######################################################################
`timescale 1ns/1ps
`default_nettype none

module lsu_asserts
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      i_arst_n,
    input  logic      i_valid,
    input  logic      i_ag_valid,
    input  logic      i_out_valid,
    input  logic      i_dc_we,
    input  logic      i_dc_hit,
    input  lsu_addr_t i_dc_addr,
    input  lsu_func_t i_dc_func
);

    // Store at the memory port that breaks the halfword or word alignment rule
    logic bad_align;

    // The memory port carries a store function
    logic store_func;

    assign bad_align  = ((i_dc_func == LSU_FUNC_SH) && (i_dc_addr % 2 != 0)) ||
                        ((i_dc_func == LSU_FUNC_SW) && (i_dc_addr % 4 != 0));

    assign store_func = i_dc_func inside {LSU_FUNC_SB, LSU_FUNC_SH, LSU_FUNC_SW};

    // Fixed two cycle latency in both directions, with nothing dropped or added
    valid_latency: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_out_valid == $past(i_valid, 2))
        else $error("o_valid does not follow i_valid by two cycles");

    // A write that reaches the array belongs to an aligned store
    // Misses are kept out by the window hit on the array side
    no_write_on_fault: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_dc_we && i_dc_hit) |-> (store_func && !bad_align))
        else $error("memory write issued for a faulting operation");

    // Both valid registers are cleared while reset is held
    valid_low_in_reset: assert property (@(posedge clk)
        !i_arst_n |-> (!i_ag_valid && !i_out_valid))
        else $error("valid high during reset");

endmodule

bind lsu_top lsu_asserts lsu_asserts_i (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_valid     (i_valid),
    .i_ag_valid  (ag_valid),
    .i_out_valid (o_valid),
    .i_dc_we     (dc_we),
    .i_dc_hit    (dc_hit),
    .i_dc_addr   (dc_addr),
    .i_dc_func   (dc_func)
);

`default_nettype wire

//--- verif/lsu_tb.sv
// ######################################################################
// Directed LSU testbench. Results are expected in issue order, and the
// byte model starts from a full SW fill, so every load reads known data
// ######################################################################
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
();

    localparam int CLK_PERIOD  = 100;
    localparam int DRAIN_LIMIT = 20;
    localparam int MEM_AW      = $clog2(DMEM_BYTES);

    logic      clk;
    logic      arst_n;
    logic      in_valid;
    lsu_func_t in_func;
    lsu_addr_t in_base;
    lsu_addr_t in_offset;
    lsu_tag_t  in_tag;
    lsu_data_t in_wdata;
    logic      out_valid;
    lsu_data_t out_data;
    lsu_addr_t out_addr;
    lsu_tag_t  out_tag;
    logic      out_fault;

    // Byte model of the data memory window
    logic [7:0] ref_mem [DMEM_BYTES];

    // Expected results, one entry per issued operation, oldest first
    lsu_tag_t  exp_tag_q   [$];
    lsu_addr_t exp_addr_q  [$];
    lsu_data_t exp_data_q  [$];
    logic      exp_fault_q [$];
    logic      exp_load_q  [$];

    lsu_top dut_i (
        .clk          (clk),
        .i_arst_n     (arst_n),
        .i_valid      (in_valid),
        .i_func       (in_func),
        .i_base       (in_base),
        .i_offset     (in_offset),
        .i_tag        (in_tag),
        .i_store_data (in_wdata),
        .o_valid      (out_valid),
        .o_data       (out_data),
        .o_addr       (out_addr),
        .o_tag        (out_tag),
        .o_fault      (out_fault)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    // Access size in bytes for each function
    function automatic int access_bytes(input lsu_func_t func);
        case (func)
            LSU_FUNC_LB, LSU_FUNC_LBU, LSU_FUNC_SB: return 1;
            LSU_FUNC_LH, LSU_FUNC_LHU, LSU_FUNC_SH: return 2;
            default:                                return 4;
        endcase
    endfunction

    function automatic logic is_store_op(input lsu_func_t func);
        return func inside {LSU_FUNC_SB, LSU_FUNC_SH, LSU_FUNC_SW};
    endfunction

    // Both halves change with the address so stale words stand out
    function automatic lsu_data_t fill_word(input lsu_addr_t addr);
        return {addr[15:0] ^ 16'hC3A5, addr[15:0]};
    endfunction

    // Compares one writeback pulse with the oldest expectation
    task automatic check_result();
        lsu_tag_t  tag_e;
        lsu_addr_t addr_e;
        lsu_data_t data_e;
        logic      fault_e;
        logic      load_e;
        assert (exp_tag_q.size() != 0)
            else fail_run("o_valid pulsed with no operation outstanding");
        tag_e   = exp_tag_q.pop_front();
        addr_e  = exp_addr_q.pop_front();
        data_e  = exp_data_q.pop_front();
        fault_e = exp_fault_q.pop_front();
        load_e  = exp_load_q.pop_front();
        assert (out_tag == tag_e)
            else fail_run($sformatf("mismatch o_tag: got %h expected %h", out_tag, tag_e));
        assert (out_addr == addr_e)
            else fail_run($sformatf("mismatch o_addr: got %h expected %h", out_addr, addr_e));
        assert (out_fault == fault_e)
            else fail_run($sformatf("mismatch o_fault: got %h expected %h", out_fault, fault_e));
        // Data only counts for a load that did not fault
        assert (!load_e || fault_e || out_data == data_e)
            else fail_run($sformatf("mismatch o_data: got %h expected %h", out_data, data_e));
    endtask

    // Moves to 1 ns after the next rising edge and checks any result there
    task automatic step();
        @(posedge clk);
        #1;
        if (out_valid) begin
            check_result();
        end
    endtask

    // Drives one operation for a single cycle and predicts its result
    task automatic issue(input lsu_func_t func, input lsu_addr_t base,
                         input lsu_addr_t offset, input lsu_data_t wdata);
        lsu_addr_t       addr;
        lsu_data_t       rd;
        logic [MEM_AW-1:0] idx;
        lsu_tag_t        tag;
        int              n;
        logic            fault;
        addr  = base + offset;
        n     = access_bytes(func);
        fault = ((addr % lsu_addr_t'(n)) != 0) || (addr >= DMEM_BYTES);
        tag   = lsu_tag_t'($urandom);
        rd    = '0;
        // Little endian, the lowest address holds the lowest byte
        if (!fault) begin
            for (int i = 0; i < n; i++) begin
                idx = addr[MEM_AW-1:0] + i[MEM_AW-1:0];
                if (is_store_op(func)) begin
                    ref_mem[idx] = 8'(wdata >> (8 * i));
                end else begin
                    rd = rd | (lsu_data_t'(ref_mem[idx]) << (8 * i));
                end
            end
        end
        case (func)
            LSU_FUNC_LB: rd = {{24{rd[7]}}, rd[7:0]};
            LSU_FUNC_LH: rd = {{16{rd[15]}}, rd[15:0]};
            default:     ;
        endcase
        exp_tag_q.push_back(tag);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(rd);
        exp_fault_q.push_back(fault);
        exp_load_q.push_back(!is_store_op(func));
        in_valid  = 1'b1;
        in_func   = func;
        in_base   = base;
        in_offset = offset;
        in_tag    = tag;
        in_wdata  = wdata;
        step();
    endtask

    // Idles the issue port until every outstanding result has come back
    task automatic drain();
        int waited;
        waited   = 0;
        in_valid = 1'b0;
        while (exp_tag_q.size() != 0) begin
            assert (waited < DRAIN_LIMIT)
                else fail_run("timed out waiting for o_valid of an issued operation");
            step();
            waited++;
        end
    endtask

    task automatic fill_memory();
        for (int a = 0; a < DMEM_BYTES; a += 4) begin
            issue(LSU_FUNC_SW, lsu_addr_t'(a), 32'h0, fill_word(lsu_addr_t'(a)));
        end
        drain();
    endtask

    // Offset is negative here, so the adder has to wrap the base back down
    task automatic word_store_load();
        lsu_addr_t addrs [5] = '{32'h000, 32'h010, 32'h084, 32'h200, 32'h3FC};
        foreach (addrs[k]) begin
            issue(LSU_FUNC_SW, addrs[k] + 32'd32, 32'hFFFF_FFE0, $urandom);
        end
        foreach (addrs[k]) begin
            issue(LSU_FUNC_LW, addrs[k], 32'h0, 32'h0);
        end
        drain();
    endtask

    task automatic sub_word_access();
        for (int off = 0; off < 4; off++) begin
            issue(LSU_FUNC_SB, 32'h100, off, $urandom);
        end
        for (int off = 0; off < 4; off++) begin
            issue(LSU_FUNC_LB, 32'h100, off, 32'h0);
            issue(LSU_FUNC_LBU, 32'h100, off, 32'h0);
        end
        for (int off = 0; off < 4; off += 2) begin
            issue(LSU_FUNC_SH, 32'h180, off, $urandom);
            issue(LSU_FUNC_LH, 32'h180, off, 32'h0);
            issue(LSU_FUNC_LHU, 32'h180, off, 32'h0);
        end
        drain();
    endtask

    task automatic misaligned_access();
        issue(LSU_FUNC_LH, 32'h200, 32'h1, 32'h0);
        issue(LSU_FUNC_LHU, 32'h200, 32'h3, 32'h0);
        issue(LSU_FUNC_LW, 32'h200, 32'h2, 32'h0);
        issue(LSU_FUNC_SH, 32'h200, 32'h3, $urandom);
        issue(LSU_FUNC_SW, 32'h204, 32'h1, $urandom);
        issue(LSU_FUNC_LW, 32'h200, 32'h0, 32'h0);
        issue(LSU_FUNC_LW, 32'h204, 32'h0, 32'h0);
        drain();
    endtask

    // Addresses above the window alias onto words 2 and 4 in the array
    task automatic out_of_window();
        issue(LSU_FUNC_SW, DMEM_BYTES, 32'h8, $urandom);
        issue(LSU_FUNC_SB, DMEM_BYTES, 32'h10, $urandom);
        issue(LSU_FUNC_LW, DMEM_BYTES, 32'h0, 32'h0);
        issue(LSU_FUNC_LB, 32'hFFFF_FF00, 32'hF0, 32'h0);
        issue(LSU_FUNC_LW, 32'hFFFF_FFFC, 32'h8, 32'h0);
        issue(LSU_FUNC_LW, 32'h8, 32'h0, 32'h0);
        issue(LSU_FUNC_LW, 32'h10, 32'h0, 32'h0);
        drain();
    endtask

    // Each load sits right behind a store to the same word
    task automatic back_to_back();
        issue(LSU_FUNC_SW, 32'h40, 32'h0, $urandom);
        issue(LSU_FUNC_LW, 32'h40, 32'h0, 32'h0);
        issue(LSU_FUNC_SB, 32'h40, 32'h3, $urandom);
        issue(LSU_FUNC_LW, 32'h40, 32'h0, 32'h0);
        issue(LSU_FUNC_SH, 32'h40, 32'h2, $urandom);
        issue(LSU_FUNC_LHU, 32'h40, 32'h2, 32'h0);
        issue(LSU_FUNC_LB, 32'h40, 32'h3, 32'h0);
        drain();
    endtask

    initial begin
        void'($urandom(4));
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_func   = LSU_FUNC_LW;
        in_base   = '0;
        in_offset = '0;
        in_tag    = '0;
        in_wdata  = '0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        fill_memory();
        word_store_load();
        sub_word_access();
        misaligned_access();
        out_of_window();
        back_to_back();
        if (exp_tag_q.size() != 0) begin
            fail_run("operations still outstanding at the end of the run");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- lsu_top.f
design/lsu_pkg.sv
design/lsu_ag.sv
design/lsu_dmem.sv
design/lsu_ex.sv
design/lsu_wb.sv
design/lsu_top.sv
verif/lsu_asserts.sv
verif/lsu_tb.sv

//--- Makefile
# Verilator build and run for the LSU testbench
VERILATOR   ?= verilator
TOP         ?= lsu_tb
FILELIST    ?= lsu_top.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
EXTRA_FLAGS ?=

PASS_MSG    := === PASS ===
SOURCES     := $(wildcard design/*.sv verif/*.sv)
SIM_BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST) $(EXTRA_FLAGS)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF -- "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
